// ==== Bender.yml ====
package:
  name: board_ctrl

sources:
  - source/axi_lite_pkg.sv
  - source/regmap_pkg.sv
  - source/event_hold.sv
  - source/axi_lite_slave.sv
  - source/reg_bank.sv
  - source/timebase.sv
  - source/led_blink.sv
  - source/gpio_monitor.sv
  - source/intr_ctrl.sv
  - source/board_ctrl_top.sv
  - target: test
    files:
      - test/board_ctrl_assert.sv
      - test/tb_board_ctrl.sv

// ==== source/axi_lite_pkg.sv ====
/*
 * AXI4-Lite port widths, address and data types, response codes
 */
package axi_lite_pkg;

	localparam int AXI_ADDR_W = 14; // Byte address
	localparam int AXI_DATA_W = 32;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== source/axi_lite_slave.sv ====
/*
 * AXI4-Lite slave front end
 * Write and read handshakes turned into register access strobes
 */
`timescale 1ns/1ps

module axi_lite_slave import axi_lite_pkg::*, regmap_pkg::*; (
	input  logic                  axi_aclk,
	input  logic                  axi_aresetn,
	input  axi_addr_t             axi_awaddr,
	input  logic [2:0]            axi_awprot,  // Accepted and ignored
	input  logic                  axi_awvalid,
	output logic                  axi_awready,
	input  axi_data_t             axi_wdata,
	input  logic [AXI_DATA_W/8-1:0] axi_wstrb, // Full-word writes only
	input  logic                  axi_wvalid,
	output logic                  axi_wready,
	output logic [1:0]            axi_bresp,
	output logic                  axi_bvalid,
	input  logic                  axi_bready,
	input  axi_addr_t             axi_araddr,
	input  logic [2:0]            axi_arprot,  // Accepted and ignored
	input  logic                  axi_arvalid,
	output logic                  axi_arready,
	output axi_data_t             axi_rdata,
	output logic [1:0]            axi_rresp,
	output logic                  axi_rvalid,
	input  logic                  axi_rready,
	output logic                  reg_wr,
	output reg_addr_t             wr_addr,
	output axi_data_t             wr_data,
	output reg_addr_t             rd_addr,
	input  axi_data_t             rd_data
);

	logic wr_rdy;  // Drives awready and wready together
	logic ar_take;
	logic rd_hs;

	// ==============================
	// Write path
	// ==============================
	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			wr_rdy <= 1'b0;
		end else begin
			// Hold off while a response is still pending
			wr_rdy <= !wr_rdy && axi_awvalid && axi_wvalid && !axi_bvalid;
		end
	end

	assign axi_awready = wr_rdy;
	assign axi_wready  = wr_rdy;

	assign reg_wr  = wr_rdy && axi_awvalid && axi_wvalid;
	assign wr_addr = axi_awaddr[AXI_ADDR_W-1:2];
	assign wr_data = axi_wdata;

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			axi_bvalid <= 1'b0;
		end else if (reg_wr) begin
			axi_bvalid <= 1'b1;
		end else if (axi_bready) begin
			axi_bvalid <= 1'b0;
		end
	end

	assign axi_bresp = RESP_OKAY;

	// ==============================
	// Read path
	// ==============================
	assign ar_take = !axi_arready && axi_arvalid && !axi_rvalid;
	assign rd_hs   = axi_arready && axi_arvalid;

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			axi_arready <= 1'b0;
		end else begin
			axi_arready <= ar_take;
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (ar_take) begin
			rd_addr <= axi_araddr[AXI_ADDR_W-1:2];
		end
		if (rd_hs) begin
			axi_rdata <= rd_data; // Lookup result of the registered index
		end
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			axi_rvalid <= 1'b0;
		end else if (rd_hs) begin
			axi_rvalid <= 1'b1;
		end else if (axi_rready) begin
			axi_rvalid <= 1'b0;
		end
	end

	assign axi_rresp = RESP_OKAY;

endmodule

// ==== source/board_ctrl_top.sv ====
/*
 * Board controller top level
 * AXI4-Lite front end, register bank, timebase, blinkers, GPIO and interrupts
 */
`timescale 1ns/1ps

module board_ctrl_top import axi_lite_pkg::*, regmap_pkg::*; #(
	parameter int unsigned EPOCH_CYCLES = BLINK_EPOCH_DEFAULT
) (
	input  logic                    axi_aclk,
	input  logic                    axi_aresetn,
	input  axi_addr_t               axi_awaddr,
	input  logic [2:0]              axi_awprot,
	input  logic                    axi_awvalid,
	output logic                    axi_awready,
	input  axi_data_t               axi_wdata,
	input  logic [AXI_DATA_W/8-1:0] axi_wstrb,
	input  logic                    axi_wvalid,
	output logic                    axi_wready,
	output logic [1:0]              axi_bresp,
	output logic                    axi_bvalid,
	input  logic                    axi_bready,
	input  axi_addr_t               axi_araddr,
	input  logic [2:0]              axi_arprot,
	input  logic                    axi_arvalid,
	output logic                    axi_arready,
	output axi_data_t               axi_rdata,
	output logic [1:0]              axi_rresp,
	output logic                    axi_rvalid,
	input  logic                    axi_rready,
	input  gpio_t                   gpio_in,
	input  done_t                   arb_done,
	input  logic                    vsync,
	output led_t                    led,
	output gpio_t                   gpio_out,
	output logic                    intr
);

	// ==============================
	// Internal nets
	// ==============================
	logic        reg_wr;
	reg_addr_t   wr_addr;
	axi_data_t   wr_data;
	reg_addr_t   rd_addr;
	axi_data_t   rd_data;
	axi_data_t   us_count;
	logic        blink_epoch;
	gpio_t       gpio_out_reg;
	blink_rate_t blink1;
	blink_rate_t blink2;
	gpio_t       hold_pos;
	gpio_t       hold_neg;
	gpio_t       hold_pos_clr;
	gpio_t       hold_neg_clr;
	intr_t       intr_sts;
	intr_t       intr_enb;
	intr_t       intr_clr;

	axi_lite_slave i_axi_lite_slave (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.axi_awaddr (axi_awaddr),
		.axi_awprot (axi_awprot),
		.axi_awvalid(axi_awvalid),
		.axi_awready(axi_awready),
		.axi_wdata  (axi_wdata),
		.axi_wstrb  (axi_wstrb),
		.axi_wvalid (axi_wvalid),
		.axi_wready (axi_wready),
		.axi_bresp  (axi_bresp),
		.axi_bvalid (axi_bvalid),
		.axi_bready (axi_bready),
		.axi_araddr (axi_araddr),
		.axi_arprot (axi_arprot),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rdata  (axi_rdata),
		.axi_rresp  (axi_rresp),
		.axi_rvalid (axi_rvalid),
		.axi_rready (axi_rready),
		.reg_wr     (reg_wr),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	reg_bank i_reg_bank (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.reg_wr      (reg_wr),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr),
		.us_count    (us_count),
		.gpio_in     (gpio_in),
		.hold_pos    (hold_pos),
		.hold_neg    (hold_neg),
		.intr_sts    (intr_sts),
		.rd_data     (rd_data),
		.led         (led),
		.gpio_out_reg(gpio_out_reg),
		.blink1      (blink1),
		.blink2      (blink2),
		.intr_enb    (intr_enb),
		.hold_pos_clr(hold_pos_clr),
		.hold_neg_clr(hold_neg_clr),
		.intr_clr    (intr_clr)
	);

	timebase #(.EPOCH_CYCLES(EPOCH_CYCLES)) i_timebase (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.us_count   (us_count),
		.blink_epoch(blink_epoch)
	);

	led_blink i_led_blink (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.blink_epoch (blink_epoch),
		.blink1      (blink1),
		.blink2      (blink2),
		.gpio_out_reg(gpio_out_reg),
		.gpio_out    (gpio_out)
	);

	gpio_monitor i_gpio_monitor (
		.axi_aclk    (axi_aclk),
		.axi_aresetn (axi_aresetn),
		.gpio_in     (gpio_in),
		.hold_pos_clr(hold_pos_clr),
		.hold_neg_clr(hold_neg_clr),
		.hold_pos    (hold_pos),
		.hold_neg    (hold_neg)
	);

	intr_ctrl i_intr_ctrl (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.arb_done   (arb_done),
		.vsync      (vsync),
		.intr_clr   (intr_clr),
		.intr_enb   (intr_enb),
		.intr_sts   (intr_sts),
		.intr       (intr)
	);

endmodule

// ==== source/event_hold.sv ====
/*
 * Sticky event bits with write-1-to-clear
 */
`timescale 1ns/1ps

module event_hold #(
	parameter type event_t = logic
) (
	input  logic   axi_aclk,
	input  logic   axi_aresetn,
	input  event_t set,
	input  event_t clr,
	output event_t held
);

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			held <= '0;
		end else begin
			held <= (held | set) & ~clr; // Clear wins on the same bit
		end
	end

endmodule

// ==== source/gpio_monitor.sv ====
/*
 * GPIO input rising and falling edge capture
 */
`timescale 1ns/1ps

module gpio_monitor import regmap_pkg::*; (
	input  logic  axi_aclk,
	input  logic  axi_aresetn,
	input  gpio_t gpio_in,
	input  gpio_t hold_pos_clr,
	input  gpio_t hold_neg_clr,
	output gpio_t hold_pos,
	output gpio_t hold_neg
);

	gpio_t gpio_d; // One-cycle-old copy
	gpio_t rise;
	gpio_t fall;

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			gpio_d <= '0;
		end else begin
			gpio_d <= gpio_in;
		end
	end

	assign rise = gpio_in & ~gpio_d;
	assign fall = ~gpio_in & gpio_d;

	event_hold #(.event_t(gpio_t)) i_hold_pos (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.set        (rise),
		.clr        (hold_pos_clr),
		.held       (hold_pos)
	);

	event_hold #(.event_t(gpio_t)) i_hold_neg (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.set        (fall),
		.clr        (hold_neg_clr),
		.held       (hold_neg)
	);

endmodule

// ==== source/intr_ctrl.sv ====
/*
 * Interrupt status from engine-done inputs and vsync
 * Level interrupt of enabled status bits
 */
`timescale 1ns/1ps

module intr_ctrl import regmap_pkg::*; (
	input  logic  axi_aclk,
	input  logic  axi_aresetn,
	input  done_t arb_done,
	input  logic  vsync,
	input  intr_t intr_clr,
	input  intr_t intr_enb,
	output intr_t intr_sts,
	output logic  intr
);

	logic [2:0] vsync_r; // Two sync stages plus edge history
	logic       vsync_pos;
	intr_t      intr_set;

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			vsync_r <= '0;
		end else begin
			vsync_r <= {vsync_r[1:0], vsync};
		end
	end

	assign vsync_pos = vsync_r[1] & ~vsync_r[2];

	// arb_done bits 1, 2 and 6 have no status bit
	assign intr_set = {
		arb_done[7],  // gftt
		vsync_pos,    // vsync
		arb_done[5],  // xsbl2
		arb_done[4],  // rect
		arb_done[3],  // bm
		arb_done[0]   // grb
	};

	event_hold #(.event_t(intr_t)) i_intr_hold (
		.axi_aclk   (axi_aclk),
		.axi_aresetn(axi_aresetn),
		.set        (intr_set),
		.clr        (intr_clr),
		.held       (intr_sts)
	);

	assign intr = |(intr_sts & intr_enb); // Level, not pulse

endmodule

// ==== source/led_blink.sv ====
/*
 * Two programmable-rate LED blinkers
 * Merged into the software GPIO outputs
 */
`timescale 1ns/1ps

module led_blink import regmap_pkg::*; (
	input  logic        axi_aclk,
	input  logic        axi_aresetn,
	input  logic        blink_epoch,
	input  blink_rate_t blink1,
	input  blink_rate_t blink2,
	input  gpio_t       gpio_out_reg,
	output gpio_t       gpio_out
);

	blink_rate_t rate [2];
	gpio_t       blink_led;

	assign rate[0] = blink1; // Drives bit 0
	assign rate[1] = blink2;

	// ==============================
	// One blinker per GPIO bit
	// ==============================
	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		blink_rate_t epoch_cnt;
		logic        hit;
		logic        led_q;

		assign hit = blink_epoch && (epoch_cnt == rate[ch]);

		always_ff @(posedge axi_aclk) begin
			if (!axi_aresetn) begin
				epoch_cnt <= blink_rate_t'(1);
				led_q     <= 1'b0;
			end else begin
				if (blink_epoch) begin
					epoch_cnt <= hit ? blink_rate_t'(1) : epoch_cnt + 1'b1;
				end
				if (rate[ch] == '0) begin
					led_q <= 1'b0; // Blinker off
				end else if (hit) begin
					led_q <= ~led_q;
				end
			end
		end

		assign blink_led[ch] = led_q;
	end

	assign gpio_out = gpio_out_reg | blink_led;

endmodule

// ==== source/reg_bank.sv ====
/*
 * Register bank with write decode and read multiplexer
 * Also forms the write-1-to-clear masks for the sticky registers
 */
`timescale 1ns/1ps

module reg_bank import axi_lite_pkg::*, regmap_pkg::*; (
	input  logic        axi_aclk,
	input  logic        axi_aresetn,
	input  logic        reg_wr,
	input  reg_addr_t   wr_addr,
	input  axi_data_t   wr_data,
	input  reg_addr_t   rd_addr,
	input  axi_data_t   us_count,
	input  gpio_t       gpio_in,
	input  gpio_t       hold_pos,
	input  gpio_t       hold_neg,
	input  intr_t       intr_sts,
	output axi_data_t   rd_data,
	output led_t        led,
	output gpio_t       gpio_out_reg,
	output blink_rate_t blink1,
	output blink_rate_t blink2,
	output intr_t       intr_enb,
	output gpio_t       hold_pos_clr,
	output gpio_t       hold_neg_clr,
	output intr_t       intr_clr
);

	axi_data_t testpad; // Scratch word for software

	// ==============================
	// Write decode
	// ==============================
	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			testpad      <= '0;
			led          <= LED_RESET;
			intr_enb     <= '0;
			gpio_out_reg <= '0;
			blink1       <= '0;
			blink2       <= '0;
		end else if (reg_wr) begin
			case (wr_addr)
				ADDR_TESTPAD:  testpad      <= wr_data;
				ADDR_LED:      led          <= led_t'(wr_data);
				ADDR_INTR_ENB: intr_enb     <= intr_t'(wr_data);
				ADDR_GPIO_OUT: gpio_out_reg <= gpio_t'(wr_data);
				ADDR_BLINK: begin
					blink1 <= blink_rate_t'(wr_data);
					blink2 <= wr_data[BLINK_SHIFT +: $bits(blink_rate_t)];
				end
				default: ;
			endcase
		end
	end

	// Clear masks, live only during the write strobe
	assign hold_pos_clr = (reg_wr && wr_addr == ADDR_HOLD_POS) ? gpio_t'(wr_data) : '0;
	assign hold_neg_clr = (reg_wr && wr_addr == ADDR_HOLD_NEG) ? gpio_t'(wr_data) : '0;
	assign intr_clr     = (reg_wr && wr_addr == ADDR_INTR_STS) ? intr_t'(wr_data) : '0;

	// ==============================
	// Read multiplexer
	// ==============================
	always_comb begin
		rd_data = '0; // Unmapped words read zero
		case (rd_addr)
			ADDR_VERSION:  rd_data = VERSION_ID;
			ADDR_TESTPAD:  rd_data = testpad;
			ADDR_LED:      rd_data = axi_data_t'(led);
			ADDR_TIMER:    rd_data = us_count;
			ADDR_INTR_ENB: rd_data = axi_data_t'(intr_enb);
			ADDR_INTR_STS: rd_data = axi_data_t'(intr_sts);
			ADDR_GPIO_IN:  rd_data = axi_data_t'(gpio_in);
			ADDR_GPIO_OUT: rd_data = axi_data_t'(gpio_out_reg);
			ADDR_HOLD_POS: rd_data = axi_data_t'(hold_pos);
			ADDR_HOLD_NEG: rd_data = axi_data_t'(hold_neg);
			ADDR_BLINK: begin
				rd_data[$bits(blink_rate_t)-1:0]           = blink1;
				rd_data[BLINK_SHIFT +: $bits(blink_rate_t)] = blink2;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/regmap_pkg.sv ====
/*
 * Register map of the board controller
 * Word addresses, reset values, field types and clock-rate constants
 */
package regmap_pkg;

	typedef logic [11:0] reg_addr_t; // Word index, byte address >> 2

	// ==============================
	// Word addresses
	// ==============================
	localparam reg_addr_t ADDR_VERSION  = 12'h000; // 0000h
	localparam reg_addr_t ADDR_TESTPAD  = 12'h001; // 0004h
	localparam reg_addr_t ADDR_LED      = 12'h002; // 0008h
	localparam reg_addr_t ADDR_TIMER    = 12'h004; // 0010h
	localparam reg_addr_t ADDR_INTR_ENB = 12'h005;
	localparam reg_addr_t ADDR_INTR_STS = 12'h006;
	localparam reg_addr_t ADDR_GPIO_IN  = 12'h008; // 0020h
	localparam reg_addr_t ADDR_GPIO_OUT = 12'h009;
	localparam reg_addr_t ADDR_HOLD_POS = 12'h00A;
	localparam reg_addr_t ADDR_HOLD_NEG = 12'h00B;
	localparam reg_addr_t ADDR_BLINK    = 12'h00C; // 0030h

	// Field types
	typedef logic [1:0] led_t;
	typedef logic [1:0] gpio_t;
	typedef logic [2:0] blink_rate_t;
	typedef logic [5:0] intr_t; // gftt, vsync, xsbl2, rect, bm, grb
	typedef logic [7:0] done_t;

	// Reset values
	localparam logic [31:0] VERSION_ID = 32'h0001_0003;
	localparam led_t        LED_RESET  = 2'b01;

	// Clock-rate constants for a 100 MHz axi_aclk
	localparam int unsigned US_CYCLES           = 100;
	localparam int unsigned BLINK_EPOCH_DEFAULT = 12_500_000; // 125 ms
	localparam int          BLINK_SHIFT         = 8;          // blink2 field

endpackage

// ==== source/timebase.sv ====
/*
 * Microsecond tick and free-running microsecond timer
 * Separate epoch divider for the LED blinkers
 */
`timescale 1ns/1ps

module timebase import axi_lite_pkg::*, regmap_pkg::*; #(
	parameter int unsigned EPOCH_CYCLES = BLINK_EPOCH_DEFAULT
) (
	input  logic      axi_aclk,
	input  logic      axi_aresetn,
	output axi_data_t us_count,
	output logic      blink_epoch
);

	localparam int US_W = $clog2(US_CYCLES);
	localparam int EP_W = $clog2(EPOCH_CYCLES);

	logic [US_W-1:0] us_div;
	logic [EP_W-1:0] ep_div;
	logic            us_tick;

	assign us_tick     = (us_div == US_W'(US_CYCLES - 1));
	assign blink_epoch = (ep_div == EP_W'(EPOCH_CYCLES - 1));

	always_ff @(posedge axi_aclk) begin
		if (!axi_aresetn) begin
			us_div   <= '0;
			us_count <= '0;
			ep_div   <= '0;
		end else begin
			us_div   <= us_tick ? '0 : us_div + 1'b1;
			us_count <= us_count + axi_data_t'(us_tick); // Wraps after ~71 min
			ep_div   <= blink_epoch ? '0 : ep_div + 1'b1;
		end
	end

endmodule

// ==== sources.f ====
source/axi_lite_pkg.sv
source/regmap_pkg.sv
source/event_hold.sv
source/axi_lite_slave.sv
source/reg_bank.sv
source/timebase.sv
source/led_blink.sv
source/gpio_monitor.sv
source/intr_ctrl.sv
source/board_ctrl_top.sv
test/board_ctrl_assert.sv
test/tb_board_ctrl.sv

// ==== test/board_ctrl_assert.sv ====
/*
 * Concurrent checks on the AXI4-Lite slave handshakes
 * Bound into every axi_lite_slave instance
 */
`timescale 1ns/1ps

module board_ctrl_assert import axi_lite_pkg::*, regmap_pkg::*; (
	input logic      axi_aclk,
	input logic      axi_aresetn,
	input logic      axi_awvalid,
	input logic      axi_awready,
	input logic      axi_wvalid,
	input logic      axi_wready,
	input logic      axi_bvalid,
	input logic      axi_bready,
	input logic      axi_rvalid,
	input logic      axi_rready,
	input axi_data_t axi_rdata,
	input logic      reg_wr
);

	int fail_count = 0; // Failed assertions so far

	// ==============================
	// Write channel
	// ==============================
	bvalid_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		axi_bvalid && !axi_bready |=> axi_bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	no_accept_with_resp : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		!(axi_awready && axi_bvalid))
		else begin
			$error("awready high while a write response is pending");
			fail_count++;
		end

	// One strobe per handshake, answered by a write response
	wr_in_handshake : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		reg_wr |-> axi_awvalid && axi_awready && axi_wvalid && axi_wready
			##1 !reg_wr && axi_bvalid)
		else begin
			$error("reg_wr outside a single write handshake cycle");
			fail_count++;
		end

	// Read data must not move while waiting for rready
	rvalid_held : assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
		else begin
			$error("rvalid or rdata changed before rready");
			fail_count++;
		end

endmodule

bind axi_lite_slave board_ctrl_assert i_board_ctrl_assert (
	.axi_aclk   (axi_aclk),
	.axi_aresetn(axi_aresetn),
	.axi_awvalid(axi_awvalid),
	.axi_awready(axi_awready),
	.axi_wvalid (axi_wvalid),
	.axi_wready (axi_wready),
	.axi_bvalid (axi_bvalid),
	.axi_bready (axi_bready),
	.axi_rvalid (axi_rvalid),
	.axi_rready (axi_rready),
	.axi_rdata  (axi_rdata),
	.reg_wr     (reg_wr)
);

// ==== test/tb_board_ctrl.sv ====
/*
 * Testbench for board_ctrl_top
 * Clock, reset, AXI tasks, register model with reference read, checks and summary
 */
`timescale 1ns/1ps

module tb_board_ctrl import axi_lite_pkg::*, regmap_pkg::*; ();

	localparam int EPOCH        = 40;  // Short blink epoch for simulation
	localparam int N_RW         = 12;
	localparam int N_GPIO_STEPS = 16;
	localparam int N_GPIO_ROUND = 3;
	localparam int N_INTR_STEPS = 10;
	localparam int XACT_CYCLES  = 16;  // Upper bound for one AXI transfer incl. stall
	localparam int XACTS = 12 + 2 * N_RW + 12 + N_GPIO_ROUND * 7 + N_INTR_STEPS * 3 + 14;
	localparam int IDLE  = N_GPIO_ROUND * (N_GPIO_STEPS + 4) + N_INTR_STEPS * 12
		+ 1023 + 14 * 3 * EPOCH;
	localparam int LIMIT = 2 * (8 + XACTS * XACT_CYCLES + IDLE);

	logic                    axi_aclk;
	logic                    axi_aresetn;
	axi_addr_t               axi_awaddr;
	logic [2:0]              axi_awprot;
	logic                    axi_awvalid;
	logic                    axi_awready;
	axi_data_t               axi_wdata;
	logic [AXI_DATA_W/8-1:0] axi_wstrb;
	logic                    axi_wvalid;
	logic                    axi_wready;
	logic [1:0]              axi_bresp;
	logic                    axi_bvalid;
	logic                    axi_bready;
	axi_addr_t               axi_araddr;
	logic [2:0]              axi_arprot;
	logic                    axi_arvalid;
	logic                    axi_arready;
	axi_data_t               axi_rdata;
	logic [1:0]              axi_rresp;
	logic                    axi_rvalid;
	logic                    axi_rready;
	gpio_t                   gpio_in;
	done_t                   arb_done;
	logic                    vsync;
	led_t                    led;
	gpio_t                   gpio_out;
	logic                    intr;

	// Register model, starts at reset values
	axi_data_t   m_testpad  = '0;
	led_t        m_led      = LED_RESET;
	intr_t       m_intr_enb = '0;
	intr_t       m_intr_sts = '0;
	gpio_t       m_gpio_out = '0;
	gpio_t       m_gpio_in  = '0;
	gpio_t       m_hold_pos = '0;
	gpio_t       m_hold_neg = '0;
	blink_rate_t m_blink1   = '0;
	blink_rate_t m_blink2   = '0;

	logic [31:0] lfsr = 32'h4a92_f2e2;
	int          cycle = 0;
	int          ar_cycle;
	int          checks = 0;
	int          errors = 0;
	int          err_mark = 0;
	int          tests = 0;
	int          tests_failed = 0;

	// Reads waiting for the comparing process
	reg_addr_t   addr_q[$];
	axi_data_t   got_q[$];
	axi_data_t   exp_q[$];
	event        read_done;

	reg_addr_t rw_addr [5] = '{ADDR_TESTPAD, ADDR_LED, ADDR_INTR_ENB, ADDR_GPIO_OUT, ADDR_BLINK};
	reg_addr_t unmapped [8] = '{12'h003, 12'h007, 12'h00D, 12'h00E, 12'h00F, 12'h010,
		12'h100, 12'hFFF}; // Holes plus words of dropped registers

	board_ctrl_top #(.EPOCH_CYCLES(EPOCH)) i_board_ctrl_top (.*);

	initial begin
		axi_aclk = 1'b0;
		forever #2 axi_aclk = ~axi_aclk;
	end

	always @(posedge axi_aclk) cycle <= cycle + 1;

	initial begin
		wait (cycle >= LIMIT);
		$display("Timeout: run did not complete within %0d cycles", LIMIT);
		$display("Checks failed");
		$finish;
	end

	// ==============================
	// Random numbers and reference
	// ==============================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Engine-done bits 0, 3, 4, 5, 7 map to grb, bm, rect, xsbl2, gftt
	function automatic intr_t done_to_intr(input done_t v);
		return {v[7], 1'b0, v[5], v[4], v[3], v[0]};
	endfunction

	function automatic void apply_write(input reg_addr_t a, input axi_data_t d);
		case (a)
			ADDR_TESTPAD:  m_testpad = d;
			ADDR_LED:      m_led = d[1:0];
			ADDR_INTR_ENB: m_intr_enb = d[5:0];
			ADDR_GPIO_OUT: m_gpio_out = d[1:0];
			ADDR_BLINK: begin
				m_blink1 = d[2:0];
				m_blink2 = d[10:8];
			end
			ADDR_HOLD_POS: m_hold_pos &= ~d[1:0]; // Write 1 to clear
			ADDR_HOLD_NEG: m_hold_neg &= ~d[1:0];
			ADDR_INTR_STS: m_intr_sts &= ~d[5:0];
			default: ;
		endcase
	endfunction

	function automatic axi_data_t ref_read(input reg_addr_t a);
		axi_data_t d;
		d = '0;
		case (a)
			ADDR_VERSION:  d = VERSION_ID;
			ADDR_TESTPAD:  d = m_testpad;
			ADDR_LED:      d[1:0] = m_led;
			ADDR_INTR_ENB: d[5:0] = m_intr_enb;
			ADDR_INTR_STS: d[5:0] = m_intr_sts;
			ADDR_GPIO_IN:  d[1:0] = m_gpio_in;
			ADDR_GPIO_OUT: d[1:0] = m_gpio_out;
			ADDR_HOLD_POS: d[1:0] = m_hold_pos;
			ADDR_HOLD_NEG: d[1:0] = m_hold_neg;
			ADDR_BLINK:    d = {21'b0, m_blink2, 5'b0, m_blink1};
			default: ; // Timer right after reset, unmapped words
		endcase
		return d;
	endfunction

	// ==============================
	// AXI tasks
	// ==============================
	task automatic axi_write(input reg_addr_t a, input axi_data_t d);
		int stall;
		stall = rand_bits(2);
		axi_awaddr  <= {a, 2'b00};
		axi_wdata   <= d;
		axi_awvalid <= 1'b1;
		axi_wvalid  <= 1'b1;
		do begin
			@(posedge axi_aclk);
		end while (!axi_awready);
		check_value("axi_wready", axi_wready, 1'b1);
		axi_awvalid <= 1'b0;
		axi_wvalid  <= 1'b0;
		apply_write(a, d);
		repeat (stall) @(posedge axi_aclk); // Hold off bready
		axi_bready <= 1'b1;
		do begin
			@(posedge axi_aclk);
		end while (!axi_bvalid);
		check_value("axi_bresp", axi_bresp, RESP_OKAY);
		axi_bready <= 1'b0;
	endtask

	task automatic axi_read(input reg_addr_t a, output axi_data_t d);
		int stall;
		stall = rand_bits(2);
		axi_araddr  <= {a, 2'b00};
		axi_arvalid <= 1'b1;
		do begin
			@(posedge axi_aclk);
		end while (!axi_arready);
		axi_arvalid <= 1'b0;
		ar_cycle = cycle; // Cycle where the word is looked up
		repeat (stall) @(posedge axi_aclk);
		axi_rready <= 1'b1;
		do begin
			@(posedge axi_aclk);
		end while (!axi_rvalid);
		d = axi_rdata;
		check_value("axi_rresp", axi_rresp, RESP_OKAY);
		axi_rready <= 1'b0;
	endtask

	task automatic read_check(input reg_addr_t a);
		axi_data_t d;
		axi_read(a, d);
		addr_q.push_back(a);
		got_q.push_back(d);
		exp_q.push_back(ref_read(a));
		-> read_done;
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Comparing process for all register reads
	initial begin
		reg_addr_t a;
		axi_data_t got;
		axi_data_t exp;
		forever begin
			@(read_done);
			while (got_q.size() > 0) begin
				a   = addr_q.pop_front();
				got = got_q.pop_front();
				exp = exp_q.pop_front();
				checks++;
				if (got !== exp) begin
					errors++;
					$display("Mismatch axi_rdata (word 0x%03h): got 0x%08h, expected 0x%08h",
						a, got, exp);
				end
			end
		end
	end

	task automatic finish_test(input string name);
		@(posedge axi_aclk);
		tests++;
		if (errors == err_mark) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic wait_toggle(output int n);
		logic start;
		start = gpio_out[0];
		n = 0;
		do begin
			@(posedge axi_aclk);
			n++;
		end while (gpio_out[0] == start);
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		axi_data_t t0;
		axi_data_t t1;
		axi_data_t d;
		reg_addr_t a;
		done_t     v;
		int        c0;
		int        span;
		int        n;
		int        iv;
		axi_aresetn = 1'b0;
		axi_awaddr  = '0;
		axi_awprot  = '0;
		axi_awvalid = 1'b0;
		axi_wdata   = '0;
		axi_wstrb   = '1;
		axi_wvalid  = 1'b0;
		axi_bready  = 1'b0;
		axi_araddr  = '0;
		axi_arprot  = '0;
		axi_arvalid = 1'b0;
		axi_rready  = 1'b0;
		gpio_in     = '0;
		arb_done    = '0;
		vsync       = 1'b0;
		repeat (8) @(posedge axi_aclk);
		axi_aresetn <= 1'b1;
		@(posedge axi_aclk);

		// Reset values, timer first while still below one tick
		read_check(ADDR_TIMER);
		read_check(ADDR_VERSION);
		read_check(ADDR_TESTPAD);
		read_check(ADDR_LED);
		read_check(ADDR_INTR_ENB);
		read_check(ADDR_INTR_STS);
		read_check(ADDR_GPIO_IN);
		read_check(ADDR_GPIO_OUT);
		read_check(ADDR_HOLD_POS);
		read_check(ADDR_HOLD_NEG);
		read_check(ADDR_BLINK);
		check_value("led", led, LED_RESET);
		check_value("gpio_out", gpio_out, 0);
		check_value("intr", intr, 0);
		finish_test("reset_values");

		// Register readback
		for (int i = 0; i < N_RW; i++) begin
			a = rw_addr[rand_bits(3) % 5];
			axi_write(a, rand_bits(32));
			read_check(a);
			check_value("led", led, m_led);
			check_value("intr", intr, 0);
		end
		foreach (unmapped[i]) begin
			read_check(unmapped[i]);
		end
		axi_write(ADDR_BLINK, 0);
		axi_write(ADDR_GPIO_OUT, rand_bits(2));
		repeat (2) @(posedge axi_aclk);
		check_value("gpio_out", gpio_out, m_gpio_out);
		finish_test("readback");

		// GPIO edge hold
		for (int r = 0; r < N_GPIO_ROUND; r++) begin
			for (int i = 0; i < N_GPIO_STEPS; i++) begin
				v = rand_bits(2);
				gpio_in <= v[1:0];
				m_hold_pos |= v[1:0] & ~m_gpio_in;
				m_hold_neg |= ~v[1:0] & m_gpio_in;
				m_gpio_in = v[1:0];
				@(posedge axi_aclk);
			end
			repeat (3) @(posedge axi_aclk);
			read_check(ADDR_GPIO_IN);
			read_check(ADDR_HOLD_POS);
			read_check(ADDR_HOLD_NEG);
			axi_write(ADDR_HOLD_POS, rand_bits(2));
			axi_write(ADDR_HOLD_NEG, rand_bits(2));
			read_check(ADDR_HOLD_POS);
			read_check(ADDR_HOLD_NEG);
		end
		finish_test("gpio_hold");

		// Interrupts
		axi_write(ADDR_INTR_ENB, rand_bits(6) | 32'h10);
		arb_done <= 8'b0100_0110; // No status bit behind these
		@(posedge axi_aclk);
		arb_done <= '0;
		repeat (3) @(posedge axi_aclk);
		read_check(ADDR_INTR_STS);
		for (int i = 0; i < N_INTR_STEPS; i++) begin
			v = rand_bits(8);
			arb_done <= v;
			m_intr_sts |= done_to_intr(v);
			@(posedge axi_aclk);
			arb_done <= '0;
			if (rand_bits(1)) begin
				vsync <= 1'b1;
				repeat (3) @(posedge axi_aclk);
				vsync <= 1'b0;
				m_intr_sts[4] = 1'b1;
			end
			repeat (5) @(posedge axi_aclk);
			check_value("intr", intr, |(m_intr_sts & m_intr_enb));
			read_check(ADDR_INTR_STS);
			if (i % 3 == 2) begin
				axi_write(ADDR_INTR_STS, rand_bits(6));
				check_value("intr", intr, |(m_intr_sts & m_intr_enb));
			end
		end
		axi_write(ADDR_INTR_STS, 32'h3F);
		check_value("intr", intr, 0);
		read_check(ADDR_INTR_STS);
		finish_test("interrupts");

		// Timer rate
		axi_read(ADDR_TIMER, t0);
		c0 = ar_cycle;
		repeat (700 + rand_bits(8)) @(posedge axi_aclk);
		axi_read(ADDR_TIMER, t1);
		span = ar_cycle - c0;
		checks++;
		if (int'(t1 - t0) + 1 < span / US_CYCLES || int'(t1 - t0) > span / US_CYCLES + 1) begin
			errors++;
			$display("Mismatch us_count delta: got 0x%0h, expected 0x%0h +/- 1 over %0d cycles",
				t1 - t0, span / US_CYCLES, span);
		end

		// Blink interval, first one may be partial
		n = rand_bits(2) % 3 + 1;
		axi_write(ADDR_GPIO_OUT, 32'h2);
		axi_write(ADDR_BLINK, n);
		wait_toggle(iv);
		for (int i = 0; i < 3; i++) begin
			wait_toggle(iv);
			check_value("blink interval", iv, n * EPOCH);
		end
		axi_write(ADDR_BLINK, 0);
		repeat (2) @(posedge axi_aclk);
		check_value("gpio_out", gpio_out, m_gpio_out);
		axi_write(ADDR_GPIO_OUT, 32'h3);
		repeat (2) @(posedge axi_aclk);
		check_value("gpio_out", gpio_out, m_gpio_out);
		finish_test("timer_blink");

		// Handshake assertion failures count as errors too
		errors += i_board_ctrl_top.i_axi_lite_slave.i_board_ctrl_assert.fail_count;
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
